//--- rtl/idecPkg.sv
// instruction decoder definitions
package idecPkg;

	// ==============================
	// basic types
	// ==============================

	// bits 9..6 major opcode, bits 39..35 function field
	typedef logic [39:0] instrT;

	// register 0 means no destination
	typedef logic [5:0] regAddrT;

	typedef enum logic [2:0] {
		unitNone   = 3'd0,
		unitBranch = 3'd1,
		unitAlu    = 3'd2,
		unitFpu    = 3'd3,
		unitLoad   = 3'd4,
		unitStore  = 3'd5
	} unitE;

	typedef enum logic [2:0] {
		byt   = 3'd0,
		wyde  = 3'd1,
		tetra = 3'd2,
		penta = 3'd3,
		octa  = 3'd4,
		deci  = 3'd5
	} memSizeE;

	// ==============================
	// opcodes
	// ==============================

	// branch unit major opcodes
	localparam logic [3:0] opBcc  = 4'd0;
	localparam logic [3:0] opBbc  = 4'd1;
	localparam logic [3:0] opBrk  = 4'd2;
	localparam logic [3:0] opJal  = 4'd3;
	localparam logic [3:0] opBeqi = 4'd4;
	localparam logic [3:0] opRet  = 4'd5;
	localparam logic [3:0] opJmp  = 4'd8;
	localparam logic [3:0] opChk  = 4'd9;
	localparam logic [3:0] opChki = 4'd10;
	localparam logic [3:0] opRti  = 4'd11;

	// sub-functions of the rti opcode
	localparam logic [4:0] fnRti  = 5'd0;
	localparam logic [4:0] fnSync = 5'd1;
	localparam logic [4:0] fnRex  = 5'd2;
	localparam logic [4:0] fnSei  = 5'd3;

	// load unit major opcodes
	localparam logic [3:0] opLdb  = 4'd0;
	localparam logic [3:0] opLdbu = 4'd1;
	localparam logic [3:0] opLdw  = 4'd2;
	localparam logic [3:0] opLdwu = 4'd3;
	localparam logic [3:0] opLdt  = 4'd4;
	localparam logic [3:0] opLdtu = 4'd5;
	localparam logic [3:0] opLdp  = 4'd6;
	localparam logic [3:0] opLdo  = 4'd7;
	localparam logic [3:0] opLdd  = 4'd8;
	localparam logic [3:0] opLea  = 4'd9;
	localparam logic [3:0] opMlx  = 4'd15;

	// store unit major opcodes
	localparam logic [3:0] opStb   = 4'd0;
	localparam logic [3:0] opStw   = 4'd2;
	localparam logic [3:0] opStt   = 4'd4;
	localparam logic [3:0] opStp   = 4'd6;
	localparam logic [3:0] opSto   = 4'd7;
	localparam logic [3:0] opStd   = 4'd8;
	localparam logic [3:0] opPush  = 4'd10;
	localparam logic [3:0] opPushc = 4'd11;
	localparam logic [3:0] opCas   = 4'd12;
	localparam logic [3:0] opMsx   = 4'd15;

	// barrier functions of the indexed store
	localparam logic [4:0] fnMemdb = 5'd16;
	localparam logic [4:0] fnMemsb = 5'd17;

	// ==============================
	// decoded record, 32 bits
	// ==============================

	typedef struct packed {
		logic    spare;
		unitE    unit;
		logic    isBranch;
		logic    isJal;
		logic    isRet;
		logic    isJmp;
		logic    isBrk;
		logic    isIrq;
		logic    isRti;
		logic    isRex;
		logic    isSei;
		logic    isSync;
		logic    isChk;
		logic    btbUpdate;
		logic    isLoad;
		logic    isStore;
		logic    isMem;
		logic    isPush;
		logic    isMemNdx;
		logic    isRmw;
		logic    isMemdb;
		logic    isMemsb;
		memSizeE memSize;
		logic    isAcquire;
		logic    isRelease;
		logic    preload;
		logic    canException;
		logic    regWrite;
	} decodedT;

endpackage

//--- rtl/branchDecoder.sv
// branch unit decoder
`timescale 1ns/1ps

module branchDecoder (
	input  logic          clk,
	input  logic          rstN,
	input  logic          stage1Load,
	input  idecPkg::instrT instr,
	output logic          isBranch,
	output logic          isJal,
	output logic          isRet,
	output logic          isJmp,
	output logic          isBrk,
	output logic          isIrq,
	output logic          isRti,
	output logic          isRex,
	output logic          isSei,
	output logic          isSync,
	output logic          isChk,
	output logic          brCanException
);
	import idecPkg::*;

	logic [3:0] opcode;
	logic [4:0] fn;
	logic       rtiOp;
	logic       brkD;
	logic       rtiD;
	logic       chkD;

	assign opcode = instr[9:6];
	assign fn     = instr[39:35];

	// rti opcode also carries sync, rex and sei
	assign rtiOp = opcode == opRti;
	assign brkD  = opcode == opBrk;
	assign rtiD  = rtiOp && fn == fnRti;
	assign chkD  = opcode == opChk || opcode == opChki;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			isBranch       <= 1'b0;
			isJal          <= 1'b0;
			isRet          <= 1'b0;
			isJmp          <= 1'b0;
			isBrk          <= 1'b0;
			isIrq          <= 1'b0;
			isRti          <= 1'b0;
			isRex          <= 1'b0;
			isSei          <= 1'b0;
			isSync         <= 1'b0;
			isChk          <= 1'b0;
			brCanException <= 1'b0;
		end else if (stage1Load) begin
			// only the directly predictable forms
			isBranch       <= opcode == opBcc || opcode == opBbc || opcode == opBeqi;
			isJal          <= opcode == opJal;
			isRet          <= opcode == opRet;
			isJmp          <= opcode == opJmp;
			isBrk          <= brkD;
			isIrq          <= brkD && instr[39];
			isRti          <= rtiD;
			isRex          <= rtiOp && fn == fnRex;
			isSei          <= rtiOp && fn == fnSei;
			isSync         <= (rtiOp && fn == fnSync) || rtiD || brkD;
			isChk          <= chkD;
			brCanException <= brkD || chkD;
		end
	end

	// the jump-class opcodes are mutually exclusive
	assert property (@(posedge clk) disable iff (!rstN)
		$onehot0({isJal, isRet, isJmp, isBrk}))
		else $error("more than one of jal, ret, jmp, brk decoded");

endmodule

//--- rtl/memDecoder.sv
// load and store unit decoder
`timescale 1ns/1ps

module memDecoder (
	input  logic            clk,
	input  logic            rstN,
	input  logic            stage1Load,
	input  idecPkg::instrT  instr,
	input  logic            isStoreUnit,
	output logic            isPush,
	output logic            isMemNdx,
	output logic            isRmw,
	output logic            isMemdb,
	output logic            isMemsb,
	output logic            isAcquire,
	output logic            isRelease,
	output idecPkg::memSizeE memSize
);
	import idecPkg::*;

	// size table of the load unit, 5-bit code covers the mlx function field
	function automatic memSizeE loadSize(input logic [4:0] code);
		case (code)
			{1'b0, opLdb}, {1'b0, opLdbu}: loadSize = byt;
			{1'b0, opLdw}, {1'b0, opLdwu}: loadSize = wyde;
			{1'b0, opLdt}, {1'b0, opLdtu}: loadSize = tetra;
			{1'b0, opLdp}:                 loadSize = penta;
			{1'b0, opLdo}:                 loadSize = octa;
			default:                       loadSize = deci;
		endcase
	endfunction

	// size table of the store unit
	function automatic memSizeE storeSize(input logic [4:0] code);
		case (code)
			{1'b0, opStb}: storeSize = byt;
			{1'b0, opStw}: storeSize = wyde;
			{1'b0, opStt}: storeSize = tetra;
			{1'b0, opStp}: storeSize = penta;
			{1'b0, opSto}: storeSize = octa;
			default:       storeSize = deci;
		endcase
	endfunction

	logic [3:0] opcode;
	logic [4:0] fn;
	logic       ndxD;
	logic [4:0] sizeCode;
	memSizeE    sizeD;

	assign opcode = instr[9:6];
	assign fn     = instr[39:35];

	// indexed forms take their size from the function field
	// mlx and msx share one major opcode
	assign ndxD     = opcode == opMlx;
	assign sizeCode = ndxD ? fn : {1'b0, opcode};
	assign sizeD    = isStoreUnit ? storeSize(sizeCode) : loadSize(sizeCode);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			isPush    <= 1'b0;
			isMemNdx  <= 1'b0;
			isRmw     <= 1'b0;
			isMemdb   <= 1'b0;
			isMemsb   <= 1'b0;
			isAcquire <= 1'b0;
			isRelease <= 1'b0;
			memSize   <= byt;
		end else if (stage1Load) begin
			isPush    <= isStoreUnit && (opcode == opPush || opcode == opPushc);
			isMemNdx  <= ndxD;
			isRmw     <= isStoreUnit && (opcode == opCas || (ndxD && fn == {1'b0, opCas}));
			isMemdb   <= isStoreUnit && ndxD && fn == fnMemdb;
			isMemsb   <= isStoreUnit && ndxD && fn == fnMemsb;
			isAcquire <= instr[39];
			isRelease <= instr[38];
			memSize   <= sizeD;
		end
	end

	// a single msx carries one barrier kind only
	assert property (@(posedge clk) disable iff (!rstN) !(isMemdb && isMemsb))
		else $error("memdb and memsb decoded together");

endmodule

//--- rtl/decodeCombine.sv
// decode merge and pipeline control
`timescale 1ns/1ps

module decodeCombine #(
	parameter bit debugSupport = 1'b1
) (
	input  logic             clk,
	input  logic             rstN,
	input  logic             inValid,
	output logic             inReady,
	input  idecPkg::unitE    inUnit,
	input  idecPkg::regAddrT inRt,
	input  logic             inDebugOn,
	output logic             stage1Load,
	output logic             isStoreUnit,
	input  logic             isBranch,
	input  logic             isJal,
	input  logic             isRet,
	input  logic             isJmp,
	input  logic             isBrk,
	input  logic             isIrq,
	input  logic             isRti,
	input  logic             isRex,
	input  logic             isSei,
	input  logic             isSync,
	input  logic             isChk,
	input  logic             brCanException,
	input  logic             isPush,
	input  logic             isMemNdx,
	input  logic             isRmw,
	input  logic             isMemdb,
	input  logic             isMemsb,
	input  logic             isAcquire,
	input  logic             isRelease,
	input  idecPkg::memSizeE memSize,
	output logic             outValid,
	input  logic             outReady,
	output idecPkg::decodedT outDecoded
);
	import idecPkg::*;

	logic    stage1Valid;
	logic    stage2Valid;
	logic    stage1Free;
	logic    stage2Free;
	unitE    unitQ;
	regAddrT rtQ;
	logic    debugQ;
	logic    brU;
	logic    ldU;
	logic    stU;
	logic    memU;
	decodedT nextRec;

	// ==============================
	// handshake
	// ==============================

	assign stage2Free  = !stage2Valid || outReady;
	assign stage1Free  = !stage1Valid || stage2Free;
	assign inReady     = stage1Free;
	assign stage1Load  = inValid && stage1Free;
	assign isStoreUnit = inUnit == unitStore;
	assign outValid    = stage2Valid;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			stage1Valid <= 1'b0;
			stage2Valid <= 1'b0;
		end else begin
			if (stage1Free)
				stage1Valid <= inValid;
			if (stage2Free)
				stage2Valid <= stage1Valid;
		end
	end

	// stage 1 side data, next to the decoder flag registers
	always_ff @(posedge clk) begin
		if (stage1Load) begin
			unitQ  <= inUnit;
			rtQ    <= inRt;
			debugQ <= inDebugOn;
		end
	end

	// ==============================
	// merge
	// ==============================

	assign brU  = unitQ == unitBranch;
	assign ldU  = unitQ == unitLoad;
	assign stU  = unitQ == unitStore;
	assign memU = ldU || stU;

	always_comb begin
		nextRec           = '0;
		nextRec.unit      = unitQ;
		nextRec.isBranch  = brU && isBranch;
		nextRec.isJal     = brU && isJal;
		nextRec.isRet     = brU && isRet;
		nextRec.isJmp     = brU && isJmp;
		nextRec.isBrk     = brU && isBrk;
		nextRec.isIrq     = brU && isIrq;
		nextRec.isRti     = brU && isRti;
		nextRec.isRex     = brU && isRex;
		nextRec.isSei     = brU && isSei;
		nextRec.isSync    = brU && isSync;
		nextRec.isChk     = brU && isChk;
		// targets that the btb cannot know ahead of time
		nextRec.btbUpdate = brU && (isJal || isRet || isBrk || isRti);
		nextRec.isLoad    = ldU;
		nextRec.isStore   = stU;
		nextRec.isMem     = memU;
		nextRec.isPush    = memU && isPush;
		nextRec.isMemNdx  = memU && isMemNdx;
		nextRec.isRmw     = memU && isRmw;
		nextRec.isMemdb   = memU && isMemdb;
		nextRec.isMemsb   = memU && isMemsb;
		nextRec.memSize   = memU ? memSize : byt;
		nextRec.isAcquire = memU && isAcquire;
		nextRec.isRelease = memU && isRelease;
		nextRec.preload   = ldU && rtQ == '0;
		nextRec.canException = (debugSupport && debugQ) || (brU && brCanException) || ldU;
		nextRec.regWrite  = rtQ != '0 && (unitQ == unitAlu || ldU
			|| (memU && (isPush || isRmw)) || (brU && (isJal || isRet)));
	end

	always_ff @(posedge clk) begin
		if (stage1Valid && stage2Free)
			outDecoded <= nextRec;
	end

	// a stalled result must not change before it is taken
	assert property (@(posedge clk) disable iff (!rstN)
		(outValid && !outReady) |=> (outValid && $stable(outDecoded)))
		else $error("output record changed while stalled");

endmodule

//--- rtl/instrDecoder.sv
// instruction decoder top
`timescale 1ns/1ps

module instrDecoder #(
	parameter bit debugSupport = 1'b1
) (
	input  logic             clk,
	input  logic             rstN,
	input  logic             inValid,
	output logic             inReady,
	input  idecPkg::unitE    inUnit,
	input  idecPkg::instrT   inInstr,
	input  idecPkg::regAddrT inRt,
	input  logic             inDebugOn,
	output logic             outValid,
	input  logic             outReady,
	output idecPkg::decodedT outDecoded
);
	import idecPkg::*;

	logic    stage1Load;
	logic    isStoreUnit;
	logic    isBranch, isJal, isRet, isJmp, isBrk, isIrq;
	logic    isRti, isRex, isSei, isSync, isChk, brCanException;
	logic    isPush, isMemNdx, isRmw, isMemdb, isMemsb;
	logic    isAcquire, isRelease;
	memSizeE memSize;

	// control-flow flags
	branchDecoder i_branchDecoder (
		.clk(clk), .rstN(rstN), .stage1Load(stage1Load), .instr(inInstr),
		.isBranch(isBranch), .isJal(isJal), .isRet(isRet), .isJmp(isJmp),
		.isBrk(isBrk), .isIrq(isIrq), .isRti(isRti), .isRex(isRex),
		.isSei(isSei), .isSync(isSync), .isChk(isChk),
		.brCanException(brCanException)
	);

	// memory flags
	memDecoder i_memDecoder (
		.clk(clk), .rstN(rstN), .stage1Load(stage1Load), .instr(inInstr),
		.isStoreUnit(isStoreUnit), .isPush(isPush), .isMemNdx(isMemNdx),
		.isRmw(isRmw), .isMemdb(isMemdb), .isMemsb(isMemsb),
		.isAcquire(isAcquire), .isRelease(isRelease), .memSize(memSize)
	);

	decodeCombine #(.debugSupport(debugSupport)) i_decodeCombine (
		.clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady),
		.inUnit(inUnit), .inRt(inRt), .inDebugOn(inDebugOn),
		.stage1Load(stage1Load), .isStoreUnit(isStoreUnit),
		.isBranch(isBranch), .isJal(isJal), .isRet(isRet), .isJmp(isJmp),
		.isBrk(isBrk), .isIrq(isIrq), .isRti(isRti), .isRex(isRex),
		.isSei(isSei), .isSync(isSync), .isChk(isChk),
		.brCanException(brCanException), .isPush(isPush),
		.isMemNdx(isMemNdx), .isRmw(isRmw), .isMemdb(isMemdb),
		.isMemsb(isMemsb), .isAcquire(isAcquire), .isRelease(isRelease),
		.memSize(memSize), .outValid(outValid), .outReady(outReady),
		.outDecoded(outDecoded)
	);

endmodule

//--- test/instrDecoderTb.sv
// instruction decoder testbench
`timescale 1ns/1ps

module instrDecoderTb;
	import idecPkg::*;

	localparam int clkPeriod     = 40;
	localparam int maxEntries    = 64;
	localparam int wordsPerEntry = 5;

	logic    clk;
	logic    rstN;
	logic    inValid;
	logic    inReady;
	unitE    inUnit;
	instrT   inInstr;
	regAddrT inRt;
	logic    inDebugOn;
	logic    outValid;
	logic    outReady;
	decodedT outDecoded;

	// word 0 is the entry count, then unit, instr, rt, debug, record per entry
	logic [39:0] traceMem [0:maxEntries * wordsPerEntry];

	decodedT expQ [$];
	decodedT heldRec;
	logic    stallSeen;
	logic    driving;
	int      numEntries;
	int      sent;
	int      received;
	int      seed;
	int      recordErrors;
	int      stallErrors;
	int      timingErrors;
	bit      limitSet;
	time     timeLimit;
	time     firstAccept;

	instrDecoder #(.debugSupport(1'b1)) i_instrDecoder (
		.clk(clk), .rstN(rstN),
		.inValid(inValid), .inReady(inReady),
		.inUnit(inUnit), .inInstr(inInstr), .inRt(inRt), .inDebugOn(inDebugOn),
		.outValid(outValid), .outReady(outReady), .outDecoded(outDecoded)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// ==============================
	// trace access and checks
	// ==============================

	function automatic decodedT traceRecord(input int idx);
		return decodedT'(traceMem[1 + idx * wordsPerEntry + 4][31:0]);
	endfunction

	task automatic presentEntry(input int idx);
		int base;
		base      = 1 + idx * wordsPerEntry;
		inValid   <= 1'b1;
		inUnit    <= unitE'(traceMem[base][2:0]);
		inInstr   <= traceMem[base + 1];
		inRt      <= traceMem[base + 2][5:0];
		inDebugOn <= traceMem[base + 3][0];
	endtask

	task automatic checkDecoded(input decodedT got, input decodedT exp, input int item);
		if (got !== exp) begin
			recordErrors++;
			$display("** Error at %0t ns: item %0d (entry %0d) decoded %h, expected %h, diff %h",
				$time, item, item % numEntries, got, exp, got ^ exp);
		end
	endtask

	task automatic heldWhileStalled(input logic validNow, input decodedT now,
		input decodedT held);
		if (validNow !== 1'b1 || now !== held) begin
			stallErrors++;
			$display("** Error at %0t ns: stalled output became valid %b record %h, held %h",
				$time, validNow, now, held);
		end
	endtask

	// ==============================
	// stimulus
	// ==============================

	// first pass back to back, second pass with random gaps on both sides
	always @(posedge clk) begin
		if (driving) begin
			if (inValid && inReady) begin
				if (sent == 0)
					firstAccept = $time;
				expQ.push_back(traceRecord(sent % numEntries));
				sent++;
			end else if (inValid && sent < numEntries) begin
				timingErrors++;
				$display("** Error at %0t ns: inReady low with no back-pressure", $time);
			end
			// a raised valid holds until its transfer
			if (!inValid || inReady) begin
				if (sent < numEntries)
					presentEntry(sent);
				else if (sent < 2 * numEntries && ($random(seed) & 1) != 0)
					presentEntry(sent % numEntries);
				else
					inValid <= 1'b0;
			end
			if (sent < numEntries || sent >= 2 * numEntries)
				outReady <= 1'b1;
			else
				outReady <= ($random(seed) % 4) != 0;
		end
	end

	// output side, sampled before the edge updates it
	always @(posedge clk) begin
		if (rstN) begin
			if (stallSeen)
				heldWhileStalled(outValid, outDecoded, heldRec);
			stallSeen = outValid && !outReady;
			heldRec   = outDecoded;
			if (outValid && outReady) begin
				if (received == 0 && $time - firstAccept != 2 * clkPeriod) begin
					timingErrors++;
					$display("** Error at %0t ns: first result %0t ns after acceptance",
						$time, $time - firstAccept);
				end
				if (expQ.size() == 0) begin
					recordErrors++;
					$display("** Error at %0t ns: record %h with none expected",
						$time, outDecoded);
				end else begin
					checkDecoded(outDecoded, expQ.pop_front(), received);
				end
				received++;
			end
		end
	end

	// ==============================
	// run control
	// ==============================

	initial begin
		clk          = 1'b0;
		rstN         = 1'b0;
		inValid      = 1'b0;
		inUnit       = unitNone;
		inInstr      = '0;
		inRt         = '0;
		inDebugOn    = 1'b0;
		outReady     = 1'b0;
		driving      = 1'b0;
		stallSeen    = 1'b0;
		heldRec      = '0;
		sent         = 0;
		received     = 0;
		recordErrors = 0;
		stallErrors  = 0;
		timingErrors = 0;
		firstAccept  = 0;
		limitSet     = 1'b0;
		seed         = 19;
		$readmemh("test/decodeTrace.txt", traceMem);
		numEntries = int'(traceMem[0]);
		if (numEntries < 1 || numEntries > maxEntries) begin
			recordErrors++;
			$display("trace file test/decodeTrace.txt is missing or has a bad entry count");
		end else begin
			// four cycles per item over both passes, plus 1 us of margin
			timeLimit = 4 * 2 * numEntries * clkPeriod + 1000;
			limitSet  = 1'b1;
			repeat (3) @(posedge clk);
			if (outValid !== 1'b0 || inReady !== 1'b1) begin
				timingErrors++;
				$display("** Error at %0t ns: handshake not idle during reset", $time);
			end
			rstN    <= 1'b1;
			driving <= 1'b1;
			wait (received >= 2 * numEntries);
			// a few more cycles catch duplicated results
			repeat (4) @(posedge clk);
		end
		$display("errors: %0d record, %0d stall, %0d timing",
			recordErrors, stallErrors, timingErrors);
		if (recordErrors + stallErrors + timingErrors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// hang guard, scaled to the trace length
	initial begin
		wait (limitSet);
		#(timeLimit);
		$display("watchdog expired at %0t ns, only %0d of %0d results came out",
			$time, received, 2 * numEntries);
		$display("errors: %0d record, %0d stall, %0d timing",
			recordErrors, stallErrors, timingErrors);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- all.f
rtl/idecPkg.sv
rtl/branchDecoder.sv
rtl/memDecoder.sv
rtl/decodeCombine.sv
rtl/instrDecoder.sv
test/instrDecoderTb.sv

//--- Bender.yml
package:
  name: instr_decoder

sources:
  - rtl/idecPkg.sv
  - rtl/branchDecoder.sv
  - rtl/memDecoder.sv
  - rtl/decodeCombine.sv
  - rtl/instrDecoder.sv
  - target: test
    files:
      - test/instrDecoderTb.sv

//--- test/decodeTrace.txt
// unit instruction rt debug expected-record, one entry per line, all hex
// the first value is the number of entries
21
1 0000ABC000 05 0 18000000 // bcc, noise in bits 23..12
1 0000000040 00 0 18000000 // bbc
1 1800000100 02 0 18000000 // beqi with a nonzero function field
1 00000000C0 01 0 14010001 // jal
1 0000000140 00 0 12010000 // ret to rt 0
1 0000000200 03 1 11000002 // jmp in debug mode
1 0000000080 00 0 10850002 // brk
1 8000000080 00 0 10C50002 // brk as irq
1 0000000240 00 0 10020002 // chk
1 0000000280 0A 0 10020002 // chki
1 00000002C0 00 0 10250000 // rti
1 08000002C0 00 0 10040000 // sync
1 10000002C0 00 0 10100000 // rex
1 18000002C0 00 0 10080000 // sei
4 0000000000 07 0 4000A003 // ldb
4 00000000C0 00 0 4000A026 // ldwu as preload
4 C000000180 02 0 4000A07B // ldp with acquire and release
4 0000000200 04 0 4000A0A3 // ldd
4 38000003C0 09 0 4000A883 // mlx, octa size
4 0000000240 00 1 4000A0A6 // lea as preload, debug mode
5 0000000000 01 1 50006002 // stb in debug mode
5 0000000100 03 0 50006040 // stt
5 40000001C0 00 0 50006088 // sto with release
5 0000000280 05 0 500070A1 // push
5 00000002C0 00 0 500070A0 // pushc to rt 0
5 0000000300 06 0 500064A1 // cas
5 10000003C0 00 0 50006820 // msx, wyde size
5 60000003C0 02 0 50006CA9 // msx cas, release bit set
5 80000003C0 00 0 50006AB0 // msx memdb
5 88000003C0 00 0 500069B0 // msx memsb
2 00000000C0 04 0 20000001 // alu carrying jal bits
3 8000000080 08 0 30000000 // fpu carrying brk bits
2 00000003C0 00 1 20000002 // alu in debug mode
